// File: include/core_config.svh
// Core sizing macros, included by every RTL file and testbench file that needs widths or depths
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data path and instruction word width
`define CORE_DATA_W 16

// Architectural registers, r0 reads as zero
`define CORE_NUM_REGS 16

// Word depths of the instruction and data memories
`define CORE_IMEM_DEPTH 256
`define CORE_DMEM_DEPTH 256

`endif

// File: src/core_pkg.sv
// Instruction word type and opcode and branch condition encodings shared by the core stages
`default_nettype none

package core_pkg;

	// One fetched word, viewed either as register format or immediate format
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [3:0] rd;
			logic [3:0] rs;
			logic [3:0] rt;
		} r_view;
		struct packed {
			logic [3:0] opcode;
			logic [3:0] rd_or_cond;
			logic [7:0] imm8;
		} i_view;
	} instr_t;

	localparam logic [3:0] OP_ADD  = 4'h0;
	localparam logic [3:0] OP_SUB  = 4'h1;
	localparam logic [3:0] OP_AND  = 4'h2;
	localparam logic [3:0] OP_NOR  = 4'h3;
	localparam logic [3:0] OP_SLL  = 4'h4;
	localparam logic [3:0] OP_SRL  = 4'h5;
	localparam logic [3:0] OP_LW   = 4'h8;
	localparam logic [3:0] OP_SW   = 4'h9;
	localparam logic [3:0] OP_LHB  = 4'hA;
	localparam logic [3:0] OP_LLB  = 4'hB;
	localparam logic [3:0] OP_B    = 4'hC;
	localparam logic [3:0] OP_HALT = 4'hF;

	// Branch conditions sit in the low two bits of rd_or_cond
	localparam logic [1:0] COND_EQ     = 2'd0;
	localparam logic [1:0] COND_NE     = 2'd1;
	localparam logic [1:0] COND_LT     = 2'd2;
	localparam logic [1:0] COND_ALWAYS = 2'd3;

endpackage

`default_nettype wire

// File: src/fetch_stage.sv
// Instruction fetch with a boot-loaded instruction memory, feeding the IF/ID register to decode
`default_nettype none
`include "core_config.svh"

module fetch_stage (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      boot_we,
	input  wire [7:0]                boot_addr,
	input  wire core_pkg::instr_t    boot_data,
	input  wire                      stall_load_use,
	input  wire                      redirect,
	input  wire [`CORE_DATA_W-1:0]   redirect_pc,
	input  wire                      halt,
	output core_pkg::instr_t         if_instr,
	output logic [`CORE_DATA_W-1:0]  if_pc
);
	import core_pkg::*;

	localparam int IMEM_AW = $clog2(`CORE_IMEM_DEPTH);

	instr_t                  imem [`CORE_IMEM_DEPTH];
	instr_t                  fetched;
	logic [`CORE_DATA_W-1:0] pc;

	assign fetched = imem[pc[IMEM_AW-1:0]];   // Word addressed, low bits only

	// Program load happens only while reset is held
	always_ff @(posedge clk) begin
		if (rst && boot_we) begin
			imem[boot_addr] <= boot_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (!halt) begin   // Frozen once halted
			if (redirect) begin
				pc <= redirect_pc;
			end else if (!stall_load_use) begin
				pc <= pc + 1'b1;
			end
		end
	end

	// IF/ID slot
	always_ff @(posedge clk) begin
		if (rst || redirect || halt) begin
			if_instr <= '0;   // ADD to r0 never writes, so it acts as a bubble
			if_pc    <= '0;
		end else if (!stall_load_use) begin
			if_instr <= fetched;
			if_pc    <= pc;
		end
	end

	// The boot port is driven by the environment and must stay quiet after reset
	assert property (@(posedge clk) boot_we |-> rst)
		else $error("boot write while the core is running");

endmodule

`default_nettype wire

// File: src/decode_stage.sv
// Decode stage with the register file, control decode and load-use stall, feeding the ID/EX slot
`default_nettype none
`include "core_config.svh"

module decode_stage (
	input  wire                      clk,
	input  wire                      rst,
	input  wire core_pkg::instr_t    if_instr,
	input  wire [`CORE_DATA_W-1:0]   if_pc,
	input  wire                      redirect,
	input  wire                      wb_en,
	input  wire [3:0]                wb_reg,
	input  wire [`CORE_DATA_W-1:0]   wb_data,
	output logic                     stall_load_use,
	output logic [`CORE_DATA_W-1:0]  id_pc,
	output logic [`CORE_DATA_W-1:0]  id_rs_val,
	output logic [`CORE_DATA_W-1:0]  id_rt_val,
	output logic [3:0]               id_rs,
	output logic [3:0]               id_rt,
	output logic [3:0]               id_rd,
	output logic [`CORE_DATA_W-1:0]  id_imm,
	output logic [3:0]               id_alu_op,
	output logic                     id_mem_read,
	output logic                     id_mem_write,
	output logic                     id_reg_write,
	output logic                     id_branch,
	output logic [1:0]               id_cond,
	output logic                     id_halt
);
	import core_pkg::*;

	logic [`CORE_DATA_W-1:0] regs [`CORE_NUM_REGS];
	logic [3:0]              rs_addr;
	logic [3:0]              rt_addr;
	logic [3:0]              rd_addr;
	logic [3:0]              alu_op;
	logic [`CORE_DATA_W-1:0] rs_val;
	logic [`CORE_DATA_W-1:0] rt_val;
	logic [`CORE_DATA_W-1:0] imm;
	logic                    reg_write;
	logic                    mem_read;
	logic                    mem_write;
	logic                    branch;
	logic                    halt_op;

	always_ff @(posedge clk) begin
		if (wb_en) begin
			regs[wb_reg] <= wb_data;
		end
	end

	// Write-before-read bypass from the writeback bus
	assign rs_val = (rs_addr == '0) ? '0 :
		(wb_en && wb_reg == rs_addr) ? wb_data : regs[rs_addr];
	assign rt_val = (rt_addr == '0) ? '0 :
		(wb_en && wb_reg == rt_addr) ? wb_data : regs[rt_addr];

	always_comb begin
		rs_addr   = '0;   // Unread ports stay on r0 so they never match a hazard
		rt_addr   = '0;
		rd_addr   = if_instr.r_view.rd;
		alu_op    = if_instr.r_view.opcode;
		reg_write = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		branch    = 1'b0;
		halt_op   = 1'b0;
		imm       = {{(`CORE_DATA_W-4){if_instr.r_view.rt[3]}}, if_instr.r_view.rt};
		case (if_instr.r_view.opcode)
			OP_ADD, OP_SUB, OP_AND, OP_NOR: begin
				rs_addr   = if_instr.r_view.rs;
				rt_addr   = if_instr.r_view.rt;
				reg_write = 1'b1;
			end
			OP_SLL, OP_SRL, OP_LW: begin   // rt field is a shift amount or offset
				rs_addr   = if_instr.r_view.rs;
				reg_write = 1'b1;
				mem_read  = (if_instr.r_view.opcode == OP_LW);
			end
			OP_SW: begin   // Store data comes from rd
				rs_addr   = if_instr.r_view.rs;
				rt_addr   = if_instr.r_view.rd;
				mem_write = 1'b1;
			end
			OP_LLB, OP_LHB, OP_B: begin
				rd_addr   = if_instr.i_view.rd_or_cond;
				imm       = {{(`CORE_DATA_W-8){if_instr.i_view.imm8[7]}}, if_instr.i_view.imm8};
				reg_write = (if_instr.i_view.opcode != OP_B);
				branch    = (if_instr.i_view.opcode == OP_B);
				if (if_instr.i_view.opcode == OP_LHB) begin
					rt_addr = if_instr.i_view.rd_or_cond;   // Low byte is kept
				end
			end
			OP_HALT: halt_op = 1'b1;
			default: ;
		endcase
		if (rd_addr == '0) begin
			reg_write = 1'b0;
		end
	end

	// A load in ID/EX always has a nonzero destination here
	assign stall_load_use = id_mem_read && id_reg_write &&
		(id_rd == rs_addr || id_rd == rt_addr);

	always_ff @(posedge clk) begin
		if (rst || stall_load_use || redirect) begin
			id_mem_read  <= 1'b0;
			id_mem_write <= 1'b0;
			id_reg_write <= 1'b0;
			id_branch    <= 1'b0;
			id_halt      <= 1'b0;
		end else begin
			id_mem_read  <= mem_read;
			id_mem_write <= mem_write;
			id_reg_write <= reg_write;
			id_branch    <= branch;
			id_halt      <= halt_op;
		end
	end

	always_ff @(posedge clk) begin
		id_pc     <= if_pc;
		id_rs_val <= rs_val;
		id_rt_val <= rt_val;
		id_rs     <= rs_addr;
		id_rt     <= rt_addr;
		id_rd     <= rd_addr;
		id_imm    <= imm;
		id_alu_op <= alu_op;
		id_cond   <= if_instr.i_view.rd_or_cond[1:0];
	end

	// Writeback comes from the memory stage, r0 must stay zero
	assert property (@(posedge clk) disable iff (rst) wb_en |-> wb_reg != '0)
		else $error("writeback to r0");

endmodule

`default_nettype wire

// File: src/execute_stage.sv
// Execute stage with operand forwarding, ALU, flags and branch resolution, feeding EX/MEM
`default_nettype none
`include "core_config.svh"

module execute_stage (
	input  wire                      clk,
	input  wire                      rst,
	input  wire [`CORE_DATA_W-1:0]   id_pc,
	input  wire [`CORE_DATA_W-1:0]   id_rs_val,
	input  wire [`CORE_DATA_W-1:0]   id_rt_val,
	input  wire [3:0]                id_rs,
	input  wire [3:0]                id_rt,
	input  wire [3:0]                id_rd,
	input  wire [`CORE_DATA_W-1:0]   id_imm,
	input  wire [3:0]                id_alu_op,
	input  wire                      id_mem_read,
	input  wire                      id_mem_write,
	input  wire                      id_reg_write,
	input  wire                      id_branch,
	input  wire [1:0]                id_cond,
	input  wire                      id_halt,
	input  wire                      wb_en,
	input  wire [3:0]                wb_reg,
	input  wire [`CORE_DATA_W-1:0]   wb_data,
	output logic                     redirect,
	output logic [`CORE_DATA_W-1:0]  redirect_pc,
	output logic [`CORE_DATA_W-1:0]  ex_result,
	output logic [`CORE_DATA_W-1:0]  ex_store_val,
	output logic [3:0]               ex_rd,
	output logic                     ex_mem_read,
	output logic                     ex_mem_write,
	output logic                     ex_reg_write,
	output logic                     ex_halt
);
	import core_pkg::*;

	logic [`CORE_DATA_W-1:0] op_a;
	logic [`CORE_DATA_W-1:0] op_b;
	logic [`CORE_DATA_W-1:0] alu_out;
	logic                    flag_z;
	logic                    flag_n;
	logic                    cond_met;

	// EX/MEM wins over writeback, a load in EX/MEM has no data yet
	assign op_a = (ex_reg_write && !ex_mem_read && ex_rd == id_rs) ? ex_result :
		(wb_en && wb_reg == id_rs) ? wb_data : id_rs_val;
	assign op_b = (ex_reg_write && !ex_mem_read && ex_rd == id_rt) ? ex_result :
		(wb_en && wb_reg == id_rt) ? wb_data : id_rt_val;

	always_comb begin
		case (id_alu_op)
			OP_ADD:        alu_out = op_a + op_b;
			OP_SUB:        alu_out = op_a - op_b;
			OP_AND:        alu_out = op_a & op_b;
			OP_NOR:        alu_out = ~(op_a | op_b);
			OP_SLL:        alu_out = op_a << id_imm[3:0];
			OP_SRL:        alu_out = op_a >> id_imm[3:0];
			OP_LW, OP_SW:  alu_out = op_a + id_imm;   // Word address
			OP_LLB:        alu_out = id_imm;
			OP_LHB:        alu_out = {id_imm[7:0], op_b[7:0]};
			default:       alu_out = '0;
		endcase
	end

	// Opcodes 0 to 5 are the ALU group that sets the flags
	always_ff @(posedge clk) begin
		if (rst) begin
			flag_z <= 1'b0;
			flag_n <= 1'b0;
		end else if (id_reg_write && !id_alu_op[3]) begin
			flag_z <= (alu_out == '0);
			flag_n <= alu_out[`CORE_DATA_W-1];
		end
	end

	always_comb begin
		case (id_cond)
			COND_EQ:     cond_met = flag_z;
			COND_NE:     cond_met = !flag_z;
			COND_LT:     cond_met = flag_n;
			COND_ALWAYS: cond_met = 1'b1;
			default:     cond_met = 1'b0;
		endcase
	end

	assign redirect    = id_branch && cond_met;
	assign redirect_pc = id_pc + 1'b1 + id_imm;

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_mem_read  <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_reg_write <= 1'b0;
			ex_halt      <= 1'b0;
		end else begin
			ex_mem_read  <= id_mem_read;
			ex_mem_write <= id_mem_write;
			ex_reg_write <= id_reg_write;
			ex_halt      <= id_halt;
		end
	end

	always_ff @(posedge clk) begin
		ex_result    <= alu_out;
		ex_store_val <= op_b;
		ex_rd        <= id_rd;
	end

	// A redirecting slot is never a stalling load, and decode squashes the slot behind it
	assert property (@(posedge clk) disable iff (rst)
		redirect |-> !id_mem_read ##1
		!(id_reg_write || id_mem_read || id_mem_write || id_branch || id_halt))
		else $error("redirect overlapped a load-use stall or leaked a slot");

endmodule

`default_nettype wire

// File: src/memory_stage.sv
// Memory stage with the data memory, result select, sticky halt and the MEM/WB writeback register
`default_nettype none
`include "core_config.svh"

module memory_stage (
	input  wire                      clk,
	input  wire                      rst,
	input  wire [`CORE_DATA_W-1:0]   ex_result,
	input  wire [`CORE_DATA_W-1:0]   ex_store_val,
	input  wire [3:0]                ex_rd,
	input  wire                      ex_mem_read,
	input  wire                      ex_mem_write,
	input  wire                      ex_reg_write,
	input  wire                      ex_halt,
	output logic                     wb_en,
	output logic [3:0]               wb_reg,
	output logic [`CORE_DATA_W-1:0]  wb_data,
	output logic                     halt
);
	localparam int DMEM_AW = $clog2(`CORE_DMEM_DEPTH);

	logic [`CORE_DATA_W-1:0] dmem [`CORE_DMEM_DEPTH];
	logic [DMEM_AW-1:0]      addr;
	logic [`CORE_DATA_W-1:0] load_data;
	logic [`CORE_DATA_W-1:0] result;

	assign addr      = ex_result[DMEM_AW-1:0];
	assign load_data = dmem[addr];   // Asynchronous read
	assign result    = ex_mem_read ? load_data : ex_result;

	// Younger stores behind a HALT must not land
	always_ff @(posedge clk) begin
		if (ex_mem_write && !halt) begin
			dmem[addr] <= ex_store_val;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_en <= 1'b0;
			halt  <= 1'b0;
		end else begin
			wb_en <= ex_reg_write && !halt;
			halt  <= halt || ex_halt;   // Sticky until reset
		end
	end

	always_ff @(posedge clk) begin
		wb_reg  <= ex_rd;
		wb_data <= result;
	end

endmodule

`default_nettype wire

// File: src/wisc_core.sv
// Top level of the five-stage core, connecting fetch, decode, execute and memory stages
`default_nettype none
`include "core_config.svh"

module wisc_core (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      boot_we,
	input  wire [7:0]                boot_addr,
	input  wire core_pkg::instr_t    boot_data,
	output logic                     halt,
	output logic                     wb_en,
	output logic [3:0]               wb_reg,
	output logic [`CORE_DATA_W-1:0]  wb_data
);
	import core_pkg::*;

	instr_t                  if_instr;
	logic [`CORE_DATA_W-1:0] if_pc;
	logic                    stall_load_use;
	logic                    redirect;
	logic [`CORE_DATA_W-1:0] redirect_pc;

	logic [`CORE_DATA_W-1:0] id_pc;
	logic [`CORE_DATA_W-1:0] id_rs_val;
	logic [`CORE_DATA_W-1:0] id_rt_val;
	logic [3:0]              id_rs;
	logic [3:0]              id_rt;
	logic [3:0]              id_rd;
	logic [`CORE_DATA_W-1:0] id_imm;
	logic [3:0]              id_alu_op;
	logic                    id_mem_read;
	logic                    id_mem_write;
	logic                    id_reg_write;
	logic                    id_branch;
	logic [1:0]              id_cond;
	logic                    id_halt;

	logic [`CORE_DATA_W-1:0] ex_result;
	logic [`CORE_DATA_W-1:0] ex_store_val;
	logic [3:0]              ex_rd;
	logic                    ex_mem_read;
	logic                    ex_mem_write;
	logic                    ex_reg_write;
	logic                    ex_halt;

	fetch_stage fetch0 (
		.clk(clk), .rst(rst), .boot_we(boot_we), .boot_addr(boot_addr),
		.boot_data(boot_data), .stall_load_use(stall_load_use), .redirect(redirect),
		.redirect_pc(redirect_pc), .halt(halt), .if_instr(if_instr), .if_pc(if_pc)
	);

	decode_stage decode0 (
		.clk(clk), .rst(rst), .if_instr(if_instr), .if_pc(if_pc), .redirect(redirect),
		.wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
		.stall_load_use(stall_load_use), .id_pc(id_pc), .id_rs_val(id_rs_val),
		.id_rt_val(id_rt_val), .id_rs(id_rs), .id_rt(id_rt), .id_rd(id_rd), .id_imm(id_imm),
		.id_alu_op(id_alu_op), .id_mem_read(id_mem_read), .id_mem_write(id_mem_write),
		.id_reg_write(id_reg_write), .id_branch(id_branch), .id_cond(id_cond),
		.id_halt(id_halt)
	);

	execute_stage execute0 (
		.clk(clk), .rst(rst), .id_pc(id_pc), .id_rs_val(id_rs_val), .id_rt_val(id_rt_val),
		.id_rs(id_rs), .id_rt(id_rt), .id_rd(id_rd), .id_imm(id_imm), .id_alu_op(id_alu_op),
		.id_mem_read(id_mem_read), .id_mem_write(id_mem_write), .id_reg_write(id_reg_write),
		.id_branch(id_branch), .id_cond(id_cond), .id_halt(id_halt),
		.wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
		.redirect(redirect), .redirect_pc(redirect_pc), .ex_result(ex_result),
		.ex_store_val(ex_store_val), .ex_rd(ex_rd), .ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write), .ex_reg_write(ex_reg_write), .ex_halt(ex_halt)
	);

	memory_stage memory0 (
		.clk(clk), .rst(rst), .ex_result(ex_result), .ex_store_val(ex_store_val),
		.ex_rd(ex_rd), .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
		.ex_reg_write(ex_reg_write), .ex_halt(ex_halt),
		.wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data), .halt(halt)
	);

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
// Free-running clock for the core testbench, instantiated once by the testbench top
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD = 5   // In ns, gives a 10 ns period
) (
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	initial clk = 1'b0;

	always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// File: tb/core_checker.sv
// Watches the core's writeback trace and halt output and compares them with the expected writes
`default_nettype none
`include "core_config.svh"

module core_checker (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      halt,
	input  wire                      wb_en,
	input  wire [3:0]                wb_reg,
	input  wire [`CORE_DATA_W-1:0]   wb_data,
	output int                       error_count,
	output logic                     finished
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HOLD_CYCLES = 8;   // Quiet cycles watched after halt

	logic [`CORE_DATA_W+3:0] expected [$];   // {register, value} in writeback order
	int                      seen;
	int                      quiet;

	task add_expected(input logic [3:0] rd, input logic [`CORE_DATA_W-1:0] value);
		expected.push_back({rd, value});
	endtask

	initial begin
		error_count = 0;
		finished    = 1'b0;
		seen        = 0;
		quiet       = 0;
	end

	// Outputs are registered on the rising edge, so the falling edge sees them settled
	always @(negedge clk) begin
		if (rst) begin
			if (wb_en || halt) begin
				$display("wb_en or halt went high while reset was held, at %0t", $time);
				error_count = error_count + 1;
			end
		end else if (!finished) begin
			if (wb_en) begin
				if (halt) begin
					$display("writeback to r%0d after halt, at %0t", wb_reg, $time);
					error_count = error_count + 1;
				end else if (seen >= expected.size()) begin
					$display("extra writeback r%0d = %h at %0t", wb_reg, wb_data, $time);
					error_count = error_count + 1;
				end else if ({wb_reg, wb_data} !== expected[seen]) begin
					$display("mismatch at %0t: writeback %0d gave r%0d = %h, expected r%0d = %h",
						$time, seen, wb_reg, wb_data, expected[seen][`CORE_DATA_W +: 4],
						expected[seen][`CORE_DATA_W-1:0]);
					error_count = error_count + 1;
				end
				seen = seen + 1;
			end
			if (halt) begin
				if (quiet == 0 && seen < expected.size()) begin
					$display("halt rose with %0d of %0d writebacks missing, at %0t",
						expected.size() - seen, expected.size(), $time);
					error_count = error_count + 1;
				end
				quiet = quiet + 1;
				finished = (quiet == HOLD_CYCLES);
			end else if (quiet != 0) begin
				$display("halt dropped again at %0t", $time);
				error_count = error_count + 1;
				quiet = 0;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_top.sv
// Testbench top: loads the test data, boots the core under reset, runs it and prints the verdict
`default_nettype none
`include "core_config.svh"

module tb_top;
	timeunit 1ns;
	timeprecision 100ps;

	import core_pkg::*;

	localparam string DATA_FILE = "tb/core_testdata.txt";

	logic                    clk;
	logic                    rst;
	logic                    boot_we;
	logic [7:0]              boot_addr;
	instr_t                  boot_data;
	logic                    halt;
	logic                    wb_en;
	logic [3:0]              wb_reg;
	logic [`CORE_DATA_W-1:0] wb_data;
	int                      error_count;
	logic                    finished;

	logic [7:0]              prog_addr [$];
	logic [`CORE_DATA_W-1:0] prog_word [$];
	int                      load_errors;
	int                      timeouts;
	int                      cycles;
	int                      limit;

	tb_clock clock0 (.clk(clk));

	wisc_core dut0 (
		.clk(clk), .rst(rst), .boot_we(boot_we), .boot_addr(boot_addr),
		.boot_data(boot_data), .halt(halt), .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data)
	);

	core_checker checker0 (
		.clk(clk), .rst(rst), .halt(halt), .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
		.error_count(error_count), .finished(finished)
	);

	// P lines fill the program and E lines go to the checker in writeback order
	task automatic read_testdata();
		int                      fd;
		int                      n;
		string                   line;
		logic [7:0]              tag;
		logic [`CORE_DATA_W-1:0] a;
		logic [`CORE_DATA_W-1:0] b;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			$display("could not open the test data file %s", DATA_FILE);
			load_errors = load_errors + 1;
		end else begin
			while ($fgets(line, fd) != 0) begin
				tag = (line.len() > 0) ? line.getc(0) : 8'h00;
				if (tag == "P" || tag == "E") begin
					n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
					if (n != 2) begin
						$display("unreadable test data line: %s", line);
						load_errors = load_errors + 1;
					end else if (tag == "P") begin
						prog_addr.push_back(a[7:0]);
						prog_word.push_back(b);
					end else begin
						checker0.add_expected(a[3:0], b);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin
		rst         = 1'b1;
		boot_we     = 1'b0;
		boot_addr   = '0;
		boot_data   = '0;
		load_errors = 0;
		timeouts    = 0;
		cycles      = 0;
		read_testdata();
		limit = 5 * prog_word.size() + 50;
		repeat (3) @(negedge clk);
		foreach (prog_word[i]) begin
			@(negedge clk);
			boot_we   = 1'b1;
			boot_addr = prog_addr[i];
			boot_data = prog_word[i];
		end
		@(negedge clk);
		boot_we = 1'b0;
		rst     = 1'b0;
		while (!finished && cycles < limit) begin
			@(posedge clk);   // Checker updates finished on the falling edge
			cycles = cycles + 1;
		end
		if (!finished) begin
			$display("timeout: the core did not halt within %0d cycles", limit);
			timeouts = 1;
		end
		$display("errors: %0d from checks, %0d from loading, %0d timeouts",
			error_count, load_errors, timeouts);
		if (error_count == 0 && load_errors == 0 && timeouts == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/core_testdata.txt
# P <word address> <instruction>, both hex, text after them is a note
# E <register> <value>, both hex, in the order the writes leave the pipeline
P 00 B185  LLB r1, 0x85
P 01 A112  LHB r1, 0x12
P 02 B203  LLB r2, 0x03
P 03 0312  ADD r3, r1, r2
P 04 1431  SUB r4, r3, r1
P 05 2543  AND r5, r4, r3
P 06 3654  NOR r6, r5, r4
P 07 4764  SLL r7, r6, 4
P 08 5878  SRL r8, r7, 8
P 09 972F  SW  r7, [r2 - 1]
P 0A 892F  LW  r9, [r2 - 1]
P 0B 0A99  ADD r10, r9, r9
P 0C C007  B eq +7, not taken
P 0D C202  B lt +2, taken
P 0E BB11  LLB r11, 0x11, flushed
P 0F BC22  LLB r12, 0x22, flushed
P 10 1D88  SUB r13, r8, r8
P 11 C107  B ne +7, not taken
P 12 C207  B lt +7, not taken
P 13 C001  B eq +1, taken
P 14 BE44  LLB r14, 0x44, flushed
P 15 0ED8  ADD r14, r13, r8
P 16 C101  B ne +1, taken
P 17 BF55  LLB r15, 0x55, flushed
P 18 C301  B always +1
P 19 BF66  LLB r15, 0x66, flushed
P 1A F000  HALT
P 1B BF77  LLB r15, 0x77, after halt
P 1C 0111  ADD r1, r1, r1, after halt
E 1 FF85
E 1 1285
E 2 0003
E 3 1288
E 4 0003
E 5 0000
E 6 FFFC
E 7 FFC0
E 8 00FF
E 9 FFC0
E A FF80
E D 0000
E E 00FF

// File: project.f
+incdir+include
src/core_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/wisc_core.sv
tb/tb_clock.sv
tb/core_checker.sv
tb/tb_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" && rm -f sim.log \
	&& verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module tb_top -f project.f \
	&& { ./obj_dir/Vtb_top > sim.log 2>&1 || true; } \
	&& grep -q "Everything OK" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
